/* Bender.yml */
package:
  name: msm_frontend

sources:
  - include_dirs:
      - .
    files:
      - msm_frontend_pkg.sv
      - sync_fifo.sv
      - slot_allocator.sv
      - slot_store.sv
      - pair_dispatch.sv
      - msm_frontend.sv
      - target: test
        files:
          - tb_msm_frontend.sv

/* msm_frontend.f */
+incdir+.
msm_frontend_pkg.sv
sync_fifo.sv
slot_allocator.sv
slot_store.sv
pair_dispatch.sv
msm_frontend.sv
tb_msm_frontend.sv

/* msm_frontend.sv */
`timescale 1ns/1ps
`include "msm_frontend_defs.svh"

module msm_frontend (
    input  logic                       clk,
    input  logic                       rstN,
    // point stream
    input  logic                       point_valid,
    output logic                       point_ready,
    input  msm_frontend_pkg::point_t   point_data,
    // scalar stream
    input  logic                       scalar_valid,
    output logic                       scalar_ready,
    input  msm_frontend_pkg::scalar_t  scalar_data,
    // dispatch toward the bucket unit
    input  logic                       out_ready,
    output logic                       out_valid,
    output msm_frontend_pkg::scalar_t  out_scalar,
    output msm_frontend_pkg::point_t   out_point,
    // loader credits
    output logic                       scalar_credit_ok,
    output logic                       affine_credit_ok
);
    import msm_frontend_pkg::*;

    logic       pf_head_valid;
    point_t     pf_head_data;
    logic       sf_head_valid;
    scalar_t    sf_head_data;
    fill_cnt_t  sf_count;
    logic       idx_full_n;
    logic       idx_head_valid;
    slot_idx_t  idx_head_data;
    logic       slot_valid;
    slot_idx_t  slot_idx;
    logic       point_accept;
    logic       pair_pop;
    logic       rd_en;
    slot_idx_t  rd_idx;
    point_t     rd_point;
    slot_mask_t release_mask;
    logic       cancel;

    ////////////////////////////////////////
    // point side
    ////////////////////////////////////////
    sync_fifo #(
        .WIDTH (`POINT_W),
        .DEPTH (`POINT_FIFO_DEPTH)
    ) point_fifo (
        .clk        (clk),
        .rstN       (rstN),
        .push       (point_valid && point_ready),
        .push_data  (point_data),
        .pop        (point_accept),
        .full_n     (point_ready),
        .head_valid (pf_head_valid),
        .head_data  (pf_head_data),
        .count      ()
    );

    // point parks once a slot is on offer
    assign point_accept = pf_head_valid && slot_valid;

    slot_allocator u_slot_allocator (
        .clk          (clk),
        .rstN         (rstN),
        .claim        (point_accept),
        .release_mask (release_mask),
        .slot_valid   (slot_valid),
        .slot_idx     (slot_idx)
    );

    // slot order queued to line up with scalars
    sync_fifo #(
        .WIDTH (`SLOT_W),
        .DEPTH (`SLOT_NUM)
    ) index_fifo (
        .clk        (clk),
        .rstN       (rstN),
        .push       (point_accept),
        .push_data  (slot_idx),
        .pop        (pair_pop),
        .full_n     (idx_full_n),
        .head_valid (idx_head_valid),
        .head_data  (idx_head_data),
        .count      ()
    );

    // one entry per busy slot, so room always exists
    a_index_never_full : assert property (
        @(posedge clk) disable iff (!rstN)
        point_accept |-> idx_full_n
    );

    slot_store u_slot_store (
        .clk              (clk),
        .rstN             (rstN),
        .wr_en            (point_accept),
        .wr_idx           (slot_idx),
        .wr_point         (pf_head_data),
        .rd_en            (rd_en),
        .rd_idx           (rd_idx),
        .cancel           (cancel),
        .rd_point         (rd_point),
        .affine_credit_ok (affine_credit_ok)
    );

    ////////////////////////////////////////
    // scalar side
    ////////////////////////////////////////
    sync_fifo #(
        .WIDTH (`SCALAR_W),
        .DEPTH (`SCALAR_FIFO_DEPTH)
    ) scalar_fifo (
        .clk        (clk),
        .rstN       (rstN),
        .push       (scalar_valid && scalar_ready),
        .push_data  (scalar_data),
        .pop        (pair_pop),
        .full_n     (scalar_ready),
        .head_valid (sf_head_valid),
        .head_data  (sf_head_data),
        .count      (sf_count)
    );

    // credit drops a pipeline short of full
    assign scalar_credit_ok =
        (sf_count < fill_cnt_t'(`SCALAR_FIFO_DEPTH - `PIPE_LATENCY));

    ////////////////////////////////////////
    // pairing and dispatch
    ////////////////////////////////////////
    pair_dispatch u_pair_dispatch (
        .clk          (clk),
        .rstN         (rstN),
        .scalar_valid (sf_head_valid),
        .scalar_head  (sf_head_data),
        .idx_valid    (idx_head_valid),
        .idx_head     (idx_head_data),
        .out_ready    (out_ready),
        .rd_point     (rd_point),
        .pop          (pair_pop),
        .rd_en        (rd_en),
        .rd_idx       (rd_idx),
        .release_mask (release_mask),
        .cancel       (cancel),
        .out_valid    (out_valid),
        .out_scalar   (out_scalar),
        .out_point    (out_point)
    );

endmodule

/* msm_frontend_defs.svh */
`ifndef MSM_FRONTEND_DEFS_SVH
`define MSM_FRONTEND_DEFS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////
// one curve point word
`define POINT_W 64
// one scalar
`define SCALAR_W 8

////////////////////////////////////////
// storage sizing
////////////////////////////////////////
// point store slots, index width must cover them
`define SLOT_NUM 16
`define SLOT_W 4
`define POINT_FIFO_DEPTH 4
// scalar queue as deep as the store, keeps pairing aligned
`define SCALAR_FIFO_DEPTH 16
// room kept back for words already in flight upstream
`define PIPE_LATENCY 3
// fill and occupancy counts, must hold the value 16
`define CNT_W 5

`endif

/* msm_frontend_pkg.sv */
`include "msm_frontend_defs.svh"

package msm_frontend_pkg;

    ////////////////////////////////////////
    // payload types
    ////////////////////////////////////////
    // one point word as parked in the store
    typedef logic [`POINT_W-1:0] point_t;
    // scalar, all ones marks the dropped bucket 0
    typedef logic [`SCALAR_W-1:0] scalar_t;

    ////////////////////////////////////////
    // bookkeeping types
    ////////////////////////////////////////
    // store slot index
    typedef logic [`SLOT_W-1:0] slot_idx_t;
    // one bit per store slot
    typedef logic [`SLOT_NUM-1:0] slot_mask_t;
    // fifo fill or store occupancy
    typedef logic [`CNT_W-1:0] fill_cnt_t;

    // allocator offer state
    typedef enum logic {
        ALLOC_SCAN,
        ALLOC_HOLD
    } alloc_state_t;

endpackage

/* pair_dispatch.sv */
`timescale 1ns/1ps

module pair_dispatch (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          scalar_valid,
    input  msm_frontend_pkg::scalar_t     scalar_head,
    input  logic                          idx_valid,
    input  msm_frontend_pkg::slot_idx_t   idx_head,
    input  logic                          out_ready,
    input  msm_frontend_pkg::point_t      rd_point,
    output logic                          pop,
    output logic                          rd_en,
    output msm_frontend_pkg::slot_idx_t   rd_idx,
    output msm_frontend_pkg::slot_mask_t  release_mask,
    output logic                          cancel,
    output logic                          out_valid,
    output msm_frontend_pkg::scalar_t     out_scalar,
    output msm_frontend_pkg::point_t      out_point
);
    import msm_frontend_pkg::*;

    logic ack;

    ////////////////////////////////////////
    // pairing
    ////////////////////////////////////////
    // scalar head meets slot head while downstream is ready
    assign ack = scalar_valid && idx_valid && out_ready;
    // both heads leave together
    assign pop = ack;

    // all-ones scalar would land in bucket 0 and is dropped
    assign cancel = ack && (&scalar_head);
    assign rd_en  = ack && !cancel;
    assign rd_idx = idx_head;

    // slot freed in the same cycle as its read or cancel
    assign release_mask = ack ? (slot_mask_t'(1) << idx_head) : '0;

    ////////////////////////////////////////
    // output stage
    ////////////////////////////////////////
    // valid and scalar delayed to meet the read data
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_scalar <= scalar_head;
        end
    end

    // store read is already registered
    assign out_point = rd_point;

    // a dispatched point was parked before it was read
    a_point_known : assert property (
        @(posedge clk) disable iff (!rstN)
        out_valid |-> !$isunknown(out_point)
    );

endmodule

/* slot_allocator.sv */
`timescale 1ns/1ps
`include "msm_frontend_defs.svh"

module slot_allocator (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          claim,
    input  msm_frontend_pkg::slot_mask_t  release_mask,
    output logic                          slot_valid,
    output msm_frontend_pkg::slot_idx_t   slot_idx
);
    import msm_frontend_pkg::*;

    alloc_state_t state;
    slot_mask_t   busy;
    slot_mask_t   busy_next;
    slot_mask_t   claim_mask;
    slot_idx_t    pick_idx;
    logic         pick_found;

    ////////////////////////////////////////
    // busy bitmap update
    ////////////////////////////////////////
    // claimed slot is always the one on offer
    assign claim_mask = claim ? (slot_mask_t'(1) << slot_idx) : '0;
    // release and claim never hit the same slot
    assign busy_next  = (busy & ~release_mask) | claim_mask;

    // lowest free index of the updated map
    // scan from the top so the lowest hit wins
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int i = `SLOT_NUM - 1; i >= 0; i--) begin
            if (!busy_next[i]) begin
                pick_found = 1'b1;
                pick_idx   = slot_idx_t'(i);
            end
        end
    end

    // pick is registered, so a freed slot shows up next cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy     <= '0;
            state    <= ALLOC_SCAN;
            slot_idx <= '0;
        end else begin
            busy     <= busy_next;
            state    <= pick_found ? ALLOC_HOLD : ALLOC_SCAN;
            slot_idx <= pick_idx;
        end
    end

    // offer only while holding a free index
    assign slot_valid = (state == ALLOC_HOLD);

    // dispatcher frees only slots it was handed
    a_release_busy_only : assert property (
        @(posedge clk) disable iff (!rstN)
        (release_mask & ~busy) == '0
    );

endmodule

/* slot_store.sv */
`timescale 1ns/1ps
`include "msm_frontend_defs.svh"

module slot_store (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         wr_en,
    input  msm_frontend_pkg::slot_idx_t  wr_idx,
    input  msm_frontend_pkg::point_t     wr_point,
    input  logic                         rd_en,
    input  msm_frontend_pkg::slot_idx_t  rd_idx,
    input  logic                         cancel,
    output msm_frontend_pkg::point_t     rd_point,
    output logic                         affine_credit_ok
);
    import msm_frontend_pkg::*;

    point_t    mem [`SLOT_NUM];
    logic      wr_en_q;
    slot_idx_t wr_idx_q;
    point_t    wr_point_q;
    fill_cnt_t occupancy;

    ////////////////////////////////////////
    // registered write port
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= wr_en;
        end
    end

    // slot index and point ride along with the strobe
    always_ff @(posedge clk) begin
        if (wr_en) begin
            wr_idx_q   <= wr_idx;
            wr_point_q <= wr_point;
        end
    end

    // ram write, one cycle after accept
    always_ff @(posedge clk) begin
        if (wr_en_q) begin
            mem[wr_idx_q] <= wr_point_q;
        end
    end

    // registered read
    // a slot may be read while its write is still pending, take the staged word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (wr_en_q && (wr_idx_q == rd_idx)) begin
                rd_point <= wr_point_q;
            end else begin
                rd_point <= mem[rd_idx];
            end
        end
    end

    ////////////////////////////////////////
    // occupancy credit
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            occupancy <= '0;
        end else begin
            case ({wr_en_q, rd_en, cancel})
                3'b001:  occupancy <= occupancy - fill_cnt_t'(1);
                3'b010:  occupancy <= occupancy - fill_cnt_t'(1);
                3'b011:  occupancy <= occupancy - fill_cnt_t'(2);
                3'b100:  occupancy <= occupancy + fill_cnt_t'(1);
                3'b111:  occupancy <= occupancy - fill_cnt_t'(1);
                default: occupancy <= occupancy;
            endcase
        end
    end

    // keep a pipeline of slots in reserve
    assign affine_credit_ok = (occupancy < fill_cnt_t'(`SLOT_NUM - `PIPE_LATENCY));

    a_occupancy_bound : assert property (
        @(posedge clk) disable iff (!rstN)
        occupancy <= fill_cnt_t'(`SLOT_NUM)
    );

endmodule

/* sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          push,
    input  logic [WIDTH-1:0]              push_data,
    input  logic                          pop,
    output logic                          full_n,
    output logic                          head_valid,
    output logic [WIDTH-1:0]              head_data,
    output msm_frontend_pkg::fill_cnt_t   count
);
    import msm_frontend_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    // plain register array, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // head shows straight out of the array
    assign head_data  = mem[rd_ptr];
    assign head_valid = (count != '0);
    assign full_n     = (count != fill_cnt_t'(DEPTH));

    ////////////////////////////////////////
    // pointers and fill count
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // wrap at DEPTH, no power of two needed
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // callers must honour full_n and head_valid
    a_no_overflow_underflow : assert property (
        @(posedge clk) disable iff (!rstN)
        !(push && !full_n) && !(pop && !head_valid)
    );

endmodule

/* tb_msm_frontend.sv */
`timescale 1ns/1ps
`include "msm_frontend_defs.svh"

module tb_msm_frontend;
    import msm_frontend_pkg::*;

    localparam int RAND_PAIRS    = 300;
    localparam int IDLE_CYCLES   = 8;
    // whole pipe at one pair per cycle, plus stage latency
    localparam int SETTLE_CYCLES = `SLOT_NUM + `POINT_FIFO_DEPTH + 4;

    logic    clk;
    logic    rstN;
    logic    point_valid;
    logic    point_ready;
    point_t  point_data;
    logic    scalar_valid;
    logic    scalar_ready;
    scalar_t scalar_data;
    logic    out_ready;
    logic    out_valid;
    scalar_t out_scalar;
    point_t  out_point;
    logic    scalar_credit_ok;
    logic    affine_credit_ok;

    // reference model state
    logic [31:0] lfsr;
    point_t      pt_q[$];
    scalar_t     sc_q[$];
    point_t      exp_pt_q[$];
    scalar_t     exp_sc_q[$];
    int          pts_acc;
    int          scs_acc;
    int          cancels;
    int          accepted;
    logic        point_taken;
    logic        scalar_taken;
    logic        prev_out_ready;

    msm_frontend dut (
        .clk              (clk),
        .rstN             (rstN),
        .point_valid      (point_valid),
        .point_ready      (point_ready),
        .point_data       (point_data),
        .scalar_valid     (scalar_valid),
        .scalar_ready     (scalar_ready),
        .scalar_data      (scalar_data),
        .out_ready        (out_ready),
        .out_valid        (out_valid),
        .out_scalar       (out_scalar),
        .out_point        (out_point),
        .scalar_credit_ok (scalar_credit_ok),
        .affine_credit_ok (affine_credit_ok)
    );

    // 20 ns period
    always #10 clk = ~clk;

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    // galois lfsr stepped once per bit taken
    // taps for x^32+x^22+x^2+x+1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            val  = {val[62:0], lfsr[0]};
        end
        return val;
    endfunction

    // about one scalar in eight hits bucket 0
    function automatic scalar_t next_scalar();
        if (rand_bits(3) == 0) begin
            return '1;
        end
        return scalar_t'(rand_bits(`SCALAR_W));
    endfunction

    task automatic stop_with_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    task automatic expect_equal(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // quiet outputs with no work in flight
    task automatic check_idle_outputs();
        @(negedge clk);
        expect_equal("out_valid", 0, out_valid);
        expect_equal("point_ready", 1, point_ready);
        expect_equal("scalar_ready", 1, scalar_ready);
        expect_equal("scalar_credit_ok", 1, scalar_credit_ok);
        expect_equal("affine_credit_ok", 1, affine_credit_ok);
    endtask

    ////////////////////////////////////////
    // monitor and model sampled mid-cycle
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (rstN) begin
            // handshakes that complete at the coming rising edge
            point_taken  = point_valid && point_ready;
            scalar_taken = scalar_valid && scalar_ready;
            if (point_taken) begin
                pt_q.push_back(point_data);
                pts_acc++;
            end
            if (scalar_taken) begin
                sc_q.push_back(scalar_data);
                scs_acc++;
            end
            // pair in arrival order
            // all-ones scalars vanish
            while (pt_q.size() > 0 && sc_q.size() > 0) begin
                if (sc_q[0] == '1) begin
                    cancels++;
                end else begin
                    exp_pt_q.push_back(pt_q[0]);
                    exp_sc_q.push_back(sc_q[0]);
                end
                void'(pt_q.pop_front());
                void'(sc_q.pop_front());
            end
            if (out_valid) begin
                expect_equal("out_ready before out_valid", 1, prev_out_ready);
                if (exp_sc_q.size() == 0) begin
                    stop_with_error("out_valid pulsed with no pair pending");
                end else begin
                    expect_equal("out_scalar", exp_sc_q[0], out_scalar);
                    expect_equal("out_point", exp_pt_q[0], out_point);
                    void'(exp_sc_q.pop_front());
                    void'(exp_pt_q.pop_front());
                end
            end
            prev_out_ready = out_ready;
        end
    end

    ////////////////////////////////////////
    // stream drivers
    ////////////////////////////////////////
    // random valids until both streams reach target accepted words
    task automatic drive_streams(input int target, input bit rand_ready);
        int cycles;
        cycles = 0;
        while (pts_acc < target || scs_acc < target || point_valid || scalar_valid) begin
            @(posedge clk);
            #2;
            // a word stays put until taken
            if (!point_valid || point_taken) begin
                point_valid = (pts_acc < target) && rand_bits(1);
                point_data  = rand_bits(`POINT_W);
            end
            if (!scalar_valid || scalar_taken) begin
                scalar_valid = (scs_acc < target) && rand_bits(1);
                scalar_data  = next_scalar();
            end
            out_ready = rand_ready ? (rand_bits(2) != 0) : 1'b1;
            cycles++;
            if (cycles > target * 40 + 200) begin
                stop_with_error("streams were not accepted in time");
            end
        end
    endtask

    // keep one stream valid until it stalls for good
    task automatic fill_stream(input bit points, output int taken);
        int start;
        int idle;
        int cycles;
        start  = points ? pts_acc : scs_acc;
        idle   = 0;
        cycles = 0;
        while (idle < IDLE_CYCLES) begin
            @(posedge clk);
            #2;
            if (points) begin
                if (!point_valid || point_taken) begin
                    point_data = rand_bits(`POINT_W);
                end
                point_valid = 1'b1;
                idle = point_ready ? 0 : idle + 1;
            end else begin
                if (!scalar_valid || scalar_taken) begin
                    scalar_data = next_scalar();
                end
                scalar_valid = 1'b1;
                idle = scalar_ready ? 0 : idle + 1;
            end
            cycles++;
            if (cycles > 200) begin
                stop_with_error("stream never stalled under back-pressure");
            end
        end
        point_valid  = 1'b0;
        scalar_valid = 1'b0;
        taken = (points ? pts_acc : scs_acc) - start;
    endtask

    // every expected pair seen, then trailing cancels leave the pipe
    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while (exp_sc_q.size() != 0 || pt_q.size() != 0 || sc_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 1000) begin
                stop_with_error({what, " did not drain"});
            end
        end
        // cancels give no pulse to wait on
        repeat (SETTLE_CYCLES) @(posedge clk);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        clk            = 1'b0;
        rstN           = 1'b0;
        point_valid    = 1'b0;
        point_data     = '0;
        scalar_valid   = 1'b0;
        scalar_data    = '0;
        out_ready      = 1'b0;
        lfsr           = 32'h0dee5172;
        pts_acc        = 0;
        scs_acc        = 0;
        cancels        = 0;
        point_taken    = 1'b0;
        scalar_taken   = 1'b0;
        prev_out_ready = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rstN = 1'b1;

        // idle state after reset
        check_idle_outputs();

        // random traffic with random downstream ready
        drive_streams(RAND_PAIRS, 1'b1);
        @(posedge clk);
        #2;
        out_ready = 1'b1;
        wait_drained("random traffic");
        if (cancels == 0) begin
            stop_with_error("no all-ones scalar was exercised");
        end
        check_idle_outputs();

        // back-pressure on points then scalars
        @(posedge clk);
        #2;
        out_ready = 1'b0;
        fill_stream(1'b1, accepted);
        expect_equal("points accepted", `SLOT_NUM + `POINT_FIFO_DEPTH, accepted);
        expect_equal("affine_credit_ok", 0, affine_credit_ok);
        fill_stream(1'b0, accepted);
        expect_equal("scalars accepted", `SCALAR_FIFO_DEPTH, accepted);
        expect_equal("scalar_credit_ok", 0, scalar_credit_ok);

        // release and supply the missing scalars
        drive_streams(pts_acc, 1'b0);
        wait_drained("back-pressure backlog");
        check_idle_outputs();

        $display("Testbench passed");
        $finish;
    end

endmodule
